//--- hw/cache_pkg.sv
package cache_pkg;

    // Data and address widths
    localparam int ADDR_W         = 16;
    localparam int WORD_W         = 16;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W         = WORD_W * WORDS_PER_LINE;
    localparam int OFF_W          = $clog2(WORDS_PER_LINE);
    localparam int TAG_W          = 12;
    localparam int NUM_SETS       = 2;
    localparam int SET_W          = $clog2(NUM_SETS);

    // Credits on both ports
    localparam int CPU_CREDITS = 2;
    localparam int CPU_PTR_W   = $clog2(CPU_CREDITS);
    localparam int CPU_CNT_W   = $clog2(CPU_CREDITS + 1);
    localparam int MEM_CREDITS = 2;
    localparam int MEM_CNT_W   = $clog2(MEM_CREDITS + 1);

    // Controller state encoding
    localparam int ST_W = 3;
    localparam logic [ST_W-1:0] ST_IDLE        = 3'd0;
    localparam logic [ST_W-1:0] ST_DECIDE      = 3'd1;
    localparam logic [ST_W-1:0] ST_MISS_ISSUE  = 3'd2;
    localparam logic [ST_W-1:0] ST_MISS_WAIT   = 3'd3;
    localparam logic [ST_W-1:0] ST_RESPOND     = 3'd4;
    localparam logic [ST_W-1:0] ST_WRITE_ISSUE = 3'd5;

    // Byte address, seen raw or split into cache fields
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [TAG_W-1:0] tag;
            logic [SET_W-1:0] set;
            logic [OFF_W-1:0] offset;
            logic             byte_sel;
        } fields;
    } cache_addr_t;

endpackage

//--- hw/cache_ifs.sv
interface way_lookup_if import cache_pkg::*; ();

    // Index and tag from the selector
    logic [SET_W-1:0]  set;
    logic [TAG_W-1:0]  tag;

    // Stored state of the indexed entry
    logic              valid;
    logic              hit;
    logic [LINE_W-1:0] line;

    modport way_side (
        input  set,
        input  tag,
        output valid,
        output hit,
        output line
    );

    modport select_side (
        output set,
        output tag,
        input  valid,
        input  hit,
        input  line
    );

endinterface

interface way_update_if import cache_pkg::*; ();

    logic              fill_en;
    logic              word_wr_en;
    logic [SET_W-1:0]  set;
    logic [TAG_W-1:0]  tag;
    logic [LINE_W-1:0] line;
    logic [OFF_W-1:0]  offset;
    logic [WORD_W-1:0] wdata;

    modport ctrl_side (
        output fill_en, word_wr_en, set, tag, line, offset, wdata
    );

    modport way_side (
        input  fill_en, word_wr_en, set, tag, line, offset, wdata
    );

endinterface

//--- hw/cpu_req_queue.sv
module cpu_req_queue import cache_pkg::*; (
    input  logic              clk,
    input  logic              i_rst,
    input  logic              i_req_valid,
    input  logic              i_req_write,
    input  cache_addr_t       i_req_addr,
    input  logic [WORD_W-1:0] i_req_wdata,
    input  logic              i_pop,
    output logic              o_head_valid,
    output logic              o_head_write,
    output cache_addr_t       o_head_addr,
    output logic [WORD_W-1:0] o_head_wdata,
    output logic              o_req_credit
);

    logic              q_write [CPU_CREDITS];
    cache_addr_t       q_addr  [CPU_CREDITS];
    logic [WORD_W-1:0] q_wdata [CPU_CREDITS];

    logic [CPU_PTR_W-1:0] wr_ptr;
    logic [CPU_PTR_W-1:0] rd_ptr;
    logic [CPU_CNT_W-1:0] count;

    function automatic logic [CPU_PTR_W-1:0] ptr_next(input logic [CPU_PTR_W-1:0] ptr);
        if (ptr == CPU_PTR_W'(CPU_CREDITS - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_req_valid) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (i_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            if (i_req_valid && !i_pop) begin
                count <= count + 1'b1;
            end else if (!i_req_valid && i_pop) begin
                count <= count - 1'b1;
            end
        end
    end

    // Entry storage, no overflow thanks to the credits
    always_ff @(posedge clk) begin
        if (i_req_valid) begin
            q_write[wr_ptr] <= i_req_write;
            q_addr[wr_ptr]  <= i_req_addr;
            q_wdata[wr_ptr] <= i_req_wdata;
        end
    end

    assign o_head_valid = (count != '0);
    assign o_head_write = q_write[rd_ptr];
    assign o_head_addr  = q_addr[rd_ptr];
    assign o_head_wdata = q_wdata[rd_ptr];

    // Every pop frees one slot for the CPU
    assign o_req_credit = i_pop;

endmodule

//--- hw/cache_way.sv
module cache_way import cache_pkg::*; (
    input logic         clk,
    input logic         i_rst,
    way_lookup_if.way_side lookup,
    way_update_if.way_side update
);

    logic [NUM_SETS-1:0] valid_q;
    logic [TAG_W-1:0]    tag_mem  [NUM_SETS];
    logic [LINE_W-1:0]   line_mem [NUM_SETS];

    // Valid bits
    always_ff @(posedge clk) begin
        if (i_rst) begin
            valid_q <= '0;
        end else if (update.fill_en) begin
            valid_q[update.set] <= 1'b1;
        end
    end

    // Tag and data arrays
    always_ff @(posedge clk) begin
        if (update.fill_en) begin
            tag_mem[update.set]  <= update.tag;
            line_mem[update.set] <= update.line;
        end else if (update.word_wr_en) begin
            // Write hit patches one word in place
            line_mem[update.set][update.offset*WORD_W +: WORD_W] <= update.wdata;
        end
    end

    // Combinational lookup
    assign lookup.valid = valid_q[lookup.set];
    assign lookup.hit   = valid_q[lookup.set] && (tag_mem[lookup.set] == lookup.tag);
    assign lookup.line  = line_mem[lookup.set];

endmodule

//--- hw/way_select.sv
module way_select import cache_pkg::*; (
    input  logic              clk,
    input  logic              i_rst,
    input  cache_addr_t       i_addr,
    input  logic              i_capture,
    input  logic              i_touch,
    input  logic              i_touch_way,
    output logic              o_hit,
    output logic              o_hit_way,
    output logic [WORD_W-1:0] o_word,
    output logic              o_victim_way,
    way_lookup_if.select_side way0,
    way_lookup_if.select_side way1
);

    // One bit per set naming the least recently used way
    logic [NUM_SETS-1:0] lru_q;
    logic [SET_W-1:0]    cap_set;

    logic [LINE_W-1:0]   sel_line;
    logic [WORD_W-1:0]   sel_word;
    logic                victim;

    assign way0.set = i_addr.fields.set;
    assign way0.tag = i_addr.fields.tag;
    assign way1.set = i_addr.fields.set;
    assign way1.tag = i_addr.fields.tag;

    assign sel_line = way1.hit ? way1.line : way0.line;
    assign sel_word = sel_line[i_addr.fields.offset*WORD_W +: WORD_W];

    // Invalid way first, then LRU
    always_comb begin
        if (!way0.valid) begin
            victim = 1'b0;
        end else if (!way1.valid) begin
            victim = 1'b1;
        end else begin
            victim = lru_q[i_addr.fields.set];
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_hit <= 1'b0;
            lru_q <= '0;
        end else begin
            if (i_capture) begin
                o_hit <= way0.hit || way1.hit;
            end
            // The touched way becomes MRU, so the other one is LRU
            if (i_touch) begin
                lru_q[cap_set] <= ~i_touch_way;
            end
        end
    end

    // Lookup results held for the controller
    always_ff @(posedge clk) begin
        if (i_capture) begin
            o_hit_way    <= way1.hit;
            o_word       <= sel_word;
            o_victim_way <= victim;
            cap_set      <= i_addr.fields.set;
        end
    end

endmodule

//--- hw/cache_ctrl.sv
module cache_ctrl import cache_pkg::*; (
    input  logic              clk,
    input  logic              i_rst,
    input  logic              i_head_valid,
    input  logic              i_head_write,
    input  cache_addr_t       i_head_addr,
    input  logic [WORD_W-1:0] i_head_wdata,
    input  logic              i_hit,
    input  logic              i_hit_way,
    input  logic [WORD_W-1:0] i_word,
    input  logic              i_victim_way,
    input  logic              i_mem_can_issue,
    input  logic              i_mem_rsp_valid,
    input  logic [LINE_W-1:0] i_mem_rsp_line,
    output logic              o_pop,
    output logic              o_capture,
    output logic              o_touch,
    output logic              o_touch_way,
    output logic              o_mem_issue,
    output logic              o_mem_write,
    output cache_addr_t       o_mem_addr,
    output logic [WORD_W-1:0] o_mem_wdata,
    output logic              o_rsp_valid,
    output logic [WORD_W-1:0] o_rsp_rdata,
    way_update_if.ctrl_side   upd0,
    way_update_if.ctrl_side   upd1
);

    logic [ST_W-1:0]   state;

    // Request taken from the queue head
    logic              req_write;
    cache_addr_t       req_addr;
    logic [WORD_W-1:0] req_wdata;
    logic [WORD_W-1:0] rsp_rdata;

    cache_addr_t       line_addr;
    logic [WORD_W-1:0] fill_word;
    logic              fill;
    logic              word_wr;
    logic              hit_now;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_head_valid) begin
                        state <= ST_DECIDE;
                    end
                end
                ST_DECIDE: begin
                    if (req_write) begin
                        state <= ST_WRITE_ISSUE;
                    end else if (i_hit) begin
                        state <= ST_RESPOND;
                    end else begin
                        state <= ST_MISS_ISSUE;
                    end
                end
                ST_MISS_ISSUE: begin
                    if (i_mem_can_issue) begin
                        state <= ST_MISS_WAIT;
                    end
                end
                ST_MISS_WAIT: begin
                    if (i_mem_rsp_valid) begin
                        state <= ST_RESPOND;
                    end
                end
                ST_RESPOND: state <= ST_IDLE;
                ST_WRITE_ISSUE: begin
                    // Write is done once the request leaves
                    if (i_mem_can_issue) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (o_pop) begin
            req_write <= i_head_write;
            req_addr  <= i_head_addr;
            req_wdata <= i_head_wdata;
        end
        if (hit_now && !req_write) begin
            rsp_rdata <= i_word;
        end else if (fill) begin
            rsp_rdata <= fill_word;
        end
    end

    assign hit_now   = (state == ST_DECIDE) && i_hit;
    assign fill      = (state == ST_MISS_WAIT) && i_mem_rsp_valid;
    assign word_wr   = hit_now && req_write;
    assign fill_word = i_mem_rsp_line[req_addr.fields.offset*WORD_W +: WORD_W];

    // Line reads go out aligned to the first word
    always_comb begin
        line_addr                 = req_addr;
        line_addr.fields.offset   = '0;
        line_addr.fields.byte_sel = 1'b0;
    end

    assign o_pop       = (state == ST_IDLE) && i_head_valid;
    assign o_capture   = o_pop;
    assign o_touch     = hit_now || fill;
    assign o_touch_way = fill ? i_victim_way : i_hit_way;

    assign o_mem_write = (state == ST_WRITE_ISSUE);
    assign o_mem_issue = ((state == ST_MISS_ISSUE) || o_mem_write) && i_mem_can_issue;
    assign o_mem_addr  = o_mem_write ? req_addr : line_addr;
    assign o_mem_wdata = req_wdata;

    assign o_rsp_valid = (state == ST_RESPOND);
    assign o_rsp_rdata = rsp_rdata;

    // Both ways see the same update, only the enables differ
    assign upd0.fill_en    = fill && !i_victim_way;
    assign upd1.fill_en    = fill && i_victim_way;
    assign upd0.word_wr_en = word_wr && !i_hit_way;
    assign upd1.word_wr_en = word_wr && i_hit_way;
    assign upd0.set        = req_addr.fields.set;
    assign upd1.set        = req_addr.fields.set;
    assign upd0.tag        = req_addr.fields.tag;
    assign upd1.tag        = req_addr.fields.tag;
    assign upd0.line       = i_mem_rsp_line;
    assign upd1.line       = i_mem_rsp_line;
    assign upd0.offset     = req_addr.fields.offset;
    assign upd1.offset     = req_addr.fields.offset;
    assign upd0.wdata      = req_wdata;
    assign upd1.wdata      = req_wdata;

endmodule

//--- hw/mem_req_port.sv
module mem_req_port import cache_pkg::*; (
    input  logic              clk,
    input  logic              i_rst,
    input  logic              i_issue,
    input  logic              i_write,
    input  cache_addr_t       i_addr,
    input  logic [WORD_W-1:0] i_wdata,
    input  logic              i_mem_credit,
    output logic              o_can_issue,
    output logic              o_mem_req_valid,
    output logic              o_mem_req_write,
    output cache_addr_t       o_mem_req_addr,
    output logic [WORD_W-1:0] o_mem_req_wdata
);

    logic [MEM_CNT_W-1:0] credits;

    // Credits held toward memory
    always_ff @(posedge clk) begin
        if (i_rst) begin
            credits <= MEM_CNT_W'(MEM_CREDITS);
        end else if (i_issue && !i_mem_credit) begin
            credits <= credits - 1'b1;
        end else if (!i_issue && i_mem_credit) begin
            credits <= credits + 1'b1;
        end
    end

    assign o_can_issue = (credits != '0);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_mem_req_valid <= 1'b0;
        end else begin
            o_mem_req_valid <= i_issue;
        end
    end

    // Request fields, held until the next issue
    always_ff @(posedge clk) begin
        if (i_issue) begin
            o_mem_req_write <= i_write;
            o_mem_req_addr  <= i_addr;
            o_mem_req_wdata <= i_wdata;
        end
    end

endmodule

//--- hw/l1_cache_top.sv
module l1_cache_top import cache_pkg::*; (
    input  logic              clk,
    input  logic              i_rst,
    // CPU side
    input  logic              i_req_valid,
    input  logic              i_req_write,
    input  logic [ADDR_W-1:0] i_req_addr,
    input  logic [WORD_W-1:0] i_req_wdata,
    output logic              o_req_credit,
    output logic              o_rsp_valid,
    output logic [WORD_W-1:0] o_rsp_rdata,
    // Memory side
    output logic              o_mem_req_valid,
    output logic              o_mem_req_write,
    output logic [ADDR_W-1:0] o_mem_req_addr,
    output logic [WORD_W-1:0] o_mem_req_wdata,
    input  logic              i_mem_rsp_valid,
    input  logic [LINE_W-1:0] i_mem_rsp_line,
    input  logic              i_mem_credit
);

    logic              head_valid;
    logic              head_write;
    cache_addr_t       head_addr;
    logic [WORD_W-1:0] head_wdata;
    logic              pop;
    logic              capture;
    logic              touch;
    logic              touch_way;
    logic              hit;
    logic              hit_way;
    logic [WORD_W-1:0] hit_word;
    logic              victim_way;
    logic              mem_can_issue;
    logic              mem_issue;
    logic              mem_write;
    cache_addr_t       mem_addr;
    logic [WORD_W-1:0] mem_wdata;
    cache_addr_t       mem_req_addr;

    way_lookup_if lk0 ();
    way_lookup_if lk1 ();
    way_update_if up0 ();
    way_update_if up1 ();

    cpu_req_queue queue_i (
        .clk(clk), .i_rst(i_rst),
        .i_req_valid(i_req_valid), .i_req_write(i_req_write),
        .i_req_addr(i_req_addr), .i_req_wdata(i_req_wdata), .i_pop(pop),
        .o_head_valid(head_valid), .o_head_write(head_write),
        .o_head_addr(head_addr), .o_head_wdata(head_wdata),
        .o_req_credit(o_req_credit)
    );

    cache_way way0_i (.clk(clk), .i_rst(i_rst), .lookup(lk0), .update(up0));
    cache_way way1_i (.clk(clk), .i_rst(i_rst), .lookup(lk1), .update(up1));

    way_select select_i (
        .clk(clk), .i_rst(i_rst), .i_addr(head_addr),
        .i_capture(capture), .i_touch(touch), .i_touch_way(touch_way),
        .o_hit(hit), .o_hit_way(hit_way), .o_word(hit_word),
        .o_victim_way(victim_way), .way0(lk0), .way1(lk1)
    );

    cache_ctrl ctrl_i (
        .clk(clk), .i_rst(i_rst),
        .i_head_valid(head_valid), .i_head_write(head_write),
        .i_head_addr(head_addr), .i_head_wdata(head_wdata),
        .i_hit(hit), .i_hit_way(hit_way), .i_word(hit_word), .i_victim_way(victim_way),
        .i_mem_can_issue(mem_can_issue), .i_mem_rsp_valid(i_mem_rsp_valid),
        .i_mem_rsp_line(i_mem_rsp_line),
        .o_pop(pop), .o_capture(capture), .o_touch(touch), .o_touch_way(touch_way),
        .o_mem_issue(mem_issue), .o_mem_write(mem_write), .o_mem_addr(mem_addr),
        .o_mem_wdata(mem_wdata), .o_rsp_valid(o_rsp_valid), .o_rsp_rdata(o_rsp_rdata),
        .upd0(up0), .upd1(up1)
    );

    mem_req_port mem_port_i (
        .clk(clk), .i_rst(i_rst),
        .i_issue(mem_issue), .i_write(mem_write), .i_addr(mem_addr),
        .i_wdata(mem_wdata), .i_mem_credit(i_mem_credit),
        .o_can_issue(mem_can_issue), .o_mem_req_valid(o_mem_req_valid),
        .o_mem_req_write(o_mem_req_write), .o_mem_req_addr(mem_req_addr),
        .o_mem_req_wdata(o_mem_req_wdata)
    );

    assign o_mem_req_addr = mem_req_addr.raw;

endmodule

//--- tests/mem_model.sv
module mem_model import cache_pkg::*; (
    input  logic              clk,
    input  logic              i_rst,
    input  logic              i_req_valid,
    input  logic              i_req_write,
    input  logic [ADDR_W-1:0] i_req_addr,
    input  logic [WORD_W-1:0] i_req_wdata,
    output logic              o_rsp_valid,
    output logic [LINE_W-1:0] o_rsp_line,
    output logic              o_credit,
    output int                o_pending,
    output int                o_errors
);
    timeunit 1ns;
    timeprecision 100ps;

    // One entry per 16-bit word, indexed by address bits 15..1
    logic [WORD_W-1:0] mem [2**(ADDR_W-1)];

    // Requests in arrival order, {write, addr, wdata}
    logic [32:0] reqs [$];
    logic [32:0] head;
    logic        busy;
    int          delay;
    int          k;

    function automatic logic [WORD_W-1:0] initial_word(input int idx);
        return WORD_W'(idx * 40503) ^ 16'h3c5a;
    endfunction

    initial begin
        o_rsp_valid = 1'b0;
        o_rsp_line  = '0;
        o_credit    = 1'b0;
        o_pending   = 0;
        o_errors    = 0;
        busy        = 1'b0;
        delay       = 0;
        for (k = 0; k < 2**(ADDR_W-1); k++) begin
            mem[k] = initial_word(k);
        end
    end

    // Serves one request at a time, in order, after 1 to 6 cycles
    always @(negedge clk) begin
        o_rsp_valid = 1'b0;
        o_credit    = 1'b0;
        if (i_rst) begin
            reqs.delete();
            busy      = 1'b0;
            o_pending = 0;
        end else begin
            if (i_req_valid) begin
                reqs.push_back({i_req_write, i_req_addr, i_req_wdata});
                o_pending++;
                assert (o_pending <= MEM_CREDITS) else begin
                    $display("Memory holds %0d outstanding requests, more than the %0d credits",
                             o_pending, MEM_CREDITS);
                    o_errors++;
                end
            end
            if (busy) begin
                delay--;
                if (delay == 0) begin
                    head = reqs.pop_front();
                    if (head[32]) begin
                        mem[head[31:17]] = head[15:0];
                    end else begin
                        for (k = 0; k < WORDS_PER_LINE; k++) begin
                            o_rsp_line[k*WORD_W +: WORD_W] = mem[{head[31:19], k[1:0]}];
                        end
                        o_rsp_valid = 1'b1;
                    end
                    // Credit goes back with the read data
                    o_credit  = 1'b1;
                    o_pending--;
                    busy      = 1'b0;
                end
            end else if (reqs.size() != 0) begin
                delay = $urandom_range(6, 1);
                busy  = 1'b1;
            end
        end
    end

endmodule

//--- tests/tb_l1_cache.sv
module tb_l1_cache import cache_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_RANDOM   = 400;
    localparam int CREDIT_LIMIT = 500;
    localparam int DRAIN_LIMIT  = 2000;

    logic              clk;
    logic              i_rst;
    logic              req_valid;
    logic              req_write;
    logic [ADDR_W-1:0] req_addr;
    logic [WORD_W-1:0] req_wdata;
    logic              req_credit;
    logic              rsp_valid;
    logic [WORD_W-1:0] rsp_rdata;
    logic              mem_req_valid;
    logic              mem_req_write;
    logic [ADDR_W-1:0] mem_req_addr;
    logic [WORD_W-1:0] mem_req_wdata;
    logic              mem_rsp_valid;
    logic [LINE_W-1:0] mem_rsp_line;
    logic              mem_credit;
    int                mem_pending;
    int                mem_errors;

    // Shadow memory and two-way LRU tag model
    logic [WORD_W-1:0] shadow [2**(ADDR_W-1)];
    logic              m_valid [2][NUM_SETS];
    logic [TAG_W-1:0]  m_tag [2][NUM_SETS];
    logic              m_lru [NUM_SETS];

    // Expected read data, and expected memory requests as {write, addr, wdata}
    logic [WORD_W-1:0] exp_rsp [$];
    logic [32:0]       exp_mem [$];
    logic [WORD_W-1:0] rsp_expect;
    logic [32:0]       mem_expect;

    logic [TAG_W-1:0]  tag_pool [4] = '{12'h0a1, 12'h3c2, 12'h5e3, 12'hf04};
    int                cpu_credits;
    int                n_checks;
    int                n_errors;
    logic              timed_out;

    l1_cache_top dut_i (
        .clk(clk), .i_rst(i_rst),
        .i_req_valid(req_valid), .i_req_write(req_write),
        .i_req_addr(req_addr), .i_req_wdata(req_wdata),
        .o_req_credit(req_credit), .o_rsp_valid(rsp_valid), .o_rsp_rdata(rsp_rdata),
        .o_mem_req_valid(mem_req_valid), .o_mem_req_write(mem_req_write),
        .o_mem_req_addr(mem_req_addr), .o_mem_req_wdata(mem_req_wdata),
        .i_mem_rsp_valid(mem_rsp_valid), .i_mem_rsp_line(mem_rsp_line),
        .i_mem_credit(mem_credit)
    );

    mem_model mem_i (
        .clk(clk), .i_rst(i_rst),
        .i_req_valid(mem_req_valid), .i_req_write(mem_req_write),
        .i_req_addr(mem_req_addr), .i_req_wdata(mem_req_wdata),
        .o_rsp_valid(mem_rsp_valid), .o_rsp_line(mem_rsp_line), .o_credit(mem_credit),
        .o_pending(mem_pending), .o_errors(mem_errors)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [WORD_W-1:0] initial_word(input int idx);
        return WORD_W'(idx * 40503) ^ 16'h3c5a;
    endfunction

    // One falling-edge cycle with credit bookkeeping
    task automatic step();
        @(negedge clk);
        req_valid = 1'b0;
        if (req_credit) begin
            cpu_credits++;
        end
        n_checks++;
        assert (cpu_credits >= 0 && cpu_credits <= CPU_CREDITS) else begin
            $display("CPU credit count out of range: %0d", cpu_credits);
            n_errors++;
        end
    endtask

    // Predict hit or miss and queue what the cache must produce
    task automatic update_models(input logic wr, input cache_addr_t a, input logic [15:0] data);
        int way;
        int w;
        int set;
        int idx;
        set = a.fields.set;
        idx = a.raw[ADDR_W-1:1];
        way = -1;
        for (w = 0; w < 2; w++) begin
            if (m_valid[w][set] && m_tag[w][set] == a.fields.tag) begin
                way = w;
            end
        end
        if (wr) begin
            shadow[idx] = data;
            exp_mem.push_back({1'b1, a.raw, data});
            if (way >= 0) begin
                m_lru[set] = (way == 0);
            end
        end else begin
            if (way < 0) begin
                // Invalid way first, then LRU
                way = !m_valid[0][set] ? 0 : (!m_valid[1][set] ? 1 : int'(m_lru[set]));
                m_valid[way][set] = 1'b1;
                m_tag[way][set]   = a.fields.tag;
                exp_mem.push_back({1'b0, a.raw[ADDR_W-1:3], 3'b000, 16'h0000});
            end
            m_lru[set] = (way == 0);
            exp_rsp.push_back(shadow[idx]);
        end
    endtask

    task automatic send_req(input logic wr, input logic [15:0] addr, input logic [15:0] data);
        int waited;
        waited = 0;
        step();
        while (cpu_credits == 0 && !timed_out) begin
            if (waited == CREDIT_LIMIT) begin
                $display("Timeout: no request credit came back within %0d cycles", CREDIT_LIMIT);
                timed_out = 1'b1;
                n_errors++;
            end else begin
                step();
                waited++;
            end
        end
        if (!timed_out) begin
            req_valid = 1'b1;
            req_write = wr;
            req_addr  = addr;
            req_wdata = data;
            cpu_credits--;
            update_models(wr, addr, data);
        end
    endtask

    // Anything still in flight between the CPU, the cache and memory
    function automatic logic traffic_pending();
        return exp_rsp.size() != 0 || exp_mem.size() != 0 || mem_pending != 0 ||
               mem_req_valid === 1'b1 || rsp_valid === 1'b1;
    endfunction

    // Waits until every read is answered and memory is idle
    task automatic drain(input string name);
        int waited;
        waited = 0;
        step();
        while (traffic_pending() && !timed_out) begin
            if (waited == DRAIN_LIMIT) begin
                $display("Timeout: %s left %0d reads and %0d memory requests unfinished",
                         name, exp_rsp.size(), exp_mem.size());
                timed_out = 1'b1;
                n_errors++;
            end else begin
                step();
                waited++;
            end
        end
        n_checks++;
        assert (cpu_credits == CPU_CREDITS) else begin
            $display("CPU holds %0d credits after %s", cpu_credits, name);
            n_errors++;
        end
        $display("test %s finished, %0d errors so far", name, n_errors + mem_errors);
    endtask

    always @(negedge clk) begin
        if (!i_rst && rsp_valid === 1'b1) begin
            n_checks++;
            assert (exp_rsp.size() != 0) else begin
                $display("Read response arrived with no read outstanding");
                n_errors++;
            end
            if (exp_rsp.size() != 0) begin
                rsp_expect = exp_rsp.pop_front();
                n_checks++;
                assert (rsp_rdata === rsp_expect) else begin
                    $display("MISMATCH o_rsp_rdata: got %h, expected %h", rsp_rdata, rsp_expect);
                    n_errors++;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (!i_rst && mem_req_valid === 1'b1) begin
            n_checks++;
            assert (exp_mem.size() != 0) else begin
                $display("Memory request issued that the tag model did not predict");
                n_errors++;
            end
            if (exp_mem.size() != 0) begin
                mem_expect = exp_mem.pop_front();
                n_checks++;
                assert (mem_req_write === mem_expect[32]) else begin
                    $display("MISMATCH o_mem_req_write: got %h, expected %h",
                             mem_req_write, mem_expect[32]);
                    n_errors++;
                end
                n_checks++;
                assert (mem_req_addr === mem_expect[31:16]) else begin
                    $display("MISMATCH o_mem_req_addr: got %h, expected %h",
                             mem_req_addr, mem_expect[31:16]);
                    n_errors++;
                end
                n_checks++;
                assert (!mem_expect[32] || mem_req_wdata === mem_expect[15:0]) else begin
                    $display("MISMATCH o_mem_req_wdata: got %h, expected %h",
                             mem_req_wdata, mem_expect[15:0]);
                    n_errors++;
                end
            end
        end
    end

    initial begin
        int i;
        void'($urandom(60971));
        i_rst       = 1'b1;
        req_valid   = 1'b0;
        req_write   = 1'b0;
        req_addr    = '0;
        req_wdata   = '0;
        cpu_credits = CPU_CREDITS;
        n_checks    = 0;
        n_errors    = 0;
        timed_out   = 1'b0;
        for (i = 0; i < 2**(ADDR_W-1); i++) begin
            shadow[i] = initial_word(i);
        end
        for (i = 0; i < NUM_SETS; i++) begin
            m_valid[0][i] = 1'b0;
            m_valid[1][i] = 1'b0;
            m_lru[i]      = 1'b0;
        end
        repeat (16) @(negedge clk);
        i_rst = 1'b0;

        // Quiet outputs until the first request
        for (i = 0; i < 8; i++) begin
            step();
            n_checks++;
            assert (!rsp_valid && !mem_req_valid && !req_credit) else begin
                $display("Cache output active before any request");
                n_errors++;
            end
        end
        send_req(1'b0, {tag_pool[0], 1'b0, 2'd2, 1'b0}, '0);
        drain("reset_and_first_read");

        // Write miss, read miss, write hit, read hit on one address
        send_req(1'b1, {tag_pool[1], 1'b1, 2'd1, 1'b0}, 16'hbeef);
        send_req(1'b0, {tag_pool[1], 1'b1, 2'd1, 1'b0}, '0);
        send_req(1'b1, {tag_pool[1], 1'b1, 2'd1, 1'b0}, 16'h1234);
        send_req(1'b0, {tag_pool[1], 1'b1, 2'd1, 1'b0}, '0);
        drain("write_through");

        // Back to back misses keep the queue full
        for (i = 0; i < 24 && !timed_out; i++) begin
            send_req(1'b0, {tag_pool[i % 4], 1'(i / 4), 2'(i), 1'b0}, '0);
        end
        drain("miss_burst");

        for (i = 0; i < NUM_RANDOM && !timed_out; i++) begin
            if ($urandom_range(4, 0) == 0) begin
                step();
            end
            send_req(($urandom_range(9, 0) < 3),
                     {tag_pool[$urandom_range(3, 0)], 1'($urandom_range(1, 0)),
                      2'($urandom_range(3, 0)), 1'b0},
                     16'($urandom));
        end
        drain("random_traffic");

        $display("Checks: %0d, errors: %0d", n_checks, n_errors + mem_errors);
        if (n_errors + mem_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
hw/cache_pkg.sv
hw/cache_ifs.sv
hw/cpu_req_queue.sv
hw/cache_way.sv
hw/way_select.sv
hw/cache_ctrl.sv
hw/mem_req_port.sv
hw/l1_cache_top.sv
tests/mem_model.sv
tests/tb_l1_cache.sv
